/* common/gb_io_pkg.sv */
/*
 * io block constants
 * interrupt bits, timer rates, DMA length and DMA states
 */
package gb_io_pkg;

   // bit positions in IF and IE
   localparam int int_vblank = 0;
   localparam int int_lcdc = 1;
   localparam int int_timer = 2;

   typedef logic [4:0] int_t;

   // serial and joypad bits never hold a value
   localparam int_t int_live_mask = int_t'((1 << int_vblank) | (1 << int_lcdc) |
                                           (1 << int_timer));

   // clocks per TIMA step, indexed by TAC[1:0]
   localparam logic [15:0] tima_period_0 = 16'd1024;
   localparam logic [15:0] tima_period_1 = 16'd16;
   localparam logic [15:0] tima_period_2 = 16'd64;
   localparam logic [15:0] tima_period_3 = 16'd256;

   localparam logic [15:0] div_period = 16'd256;

   localparam logic [7:0] dma_length = 8'd160;

   typedef enum logic [1:0] {
      dma_idle,
      dma_read,
      dma_write
   } dma_state_e;

endpackage

/* common/gb_map_pkg.sv */
/*
 * memory map of the system bus
 * bus address and byte types, region enum,
 * region bounds, mmio register addresses, RAM depths
 */
package gb_map_pkg;

   typedef logic [15:0] addr_t;
   typedef logic [7:0] data_t;

   // region_none marks a cycle without a read
   typedef enum logic [2:0] {
      region_none,
      region_wram,
      region_oam,
      region_timer,
      region_int_flag,
      region_int_enable,
      region_dma_reg,
      region_io_none
   } region_e;

   // work RAM
   localparam addr_t wram_start = 16'hC000;
   localparam addr_t wram_end = 16'hDFFF;

   // sprite attribute memory
   localparam addr_t oam_start = 16'hFE00;
   localparam addr_t oam_end = 16'hFE9F;

   // timer block, contiguous
   localparam addr_t mmio_div = 16'hFF04;
   localparam addr_t mmio_tima = 16'hFF05;
   localparam addr_t mmio_tma = 16'hFF06;
   localparam addr_t mmio_tac = 16'hFF07;

   localparam addr_t mmio_if = 16'hFF0F;
   localparam addr_t mmio_dma = 16'hFF46;
   localparam addr_t mmio_ie = 16'hFFFF;

   localparam int wram_depth = 8192;
   localparam int oam_depth = 160;

endpackage

/* dma/oam_dma.sv */
/*
 * OAM DMA engine
 * copies 160 bytes from a source page into OAM,
 * one read cycle then one write cycle per byte
 */
`timescale 1ns/10ps

module oam_dma (
   input  logic               clock,
   input  logic               reset,
   input  logic               io_we,
   input  gb_map_pkg::addr_t  bus_addr,
   input  gb_map_pkg::data_t  bus_wdata,
   input  gb_map_pkg::data_t  bus_rdata,
   output logic               dma_busy,
   output logic               dma_re,
   output logic               dma_we,
   output gb_map_pkg::addr_t  dma_addr,
   output gb_map_pkg::data_t  dma_wdata
);

   gb_io_pkg::dma_state_e state;
   logic [7:0]            offset;
   logic [7:0]            src_page;
   logic                  start;

   assign start = io_we && (bus_addr == gb_map_pkg::mmio_dma) &&
                  (state == gb_io_pkg::dma_idle);

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         state  <= gb_io_pkg::dma_idle;
         offset <= 8'd0;
      end else begin
         case (state)
            gb_io_pkg::dma_idle: begin
               if (start) begin
                  state  <= gb_io_pkg::dma_read;
                  offset <= 8'd0;
               end
            end
            gb_io_pkg::dma_read: begin
               state <= gb_io_pkg::dma_write;
            end
            gb_io_pkg::dma_write: begin
               // last byte written, release the bus
               if (offset == gb_io_pkg::dma_length - 8'd1) begin
                  state <= gb_io_pkg::dma_idle;
               end else begin
                  state  <= gb_io_pkg::dma_read;
                  offset <= offset + 8'd1;
               end
            end
            default: state <= gb_io_pkg::dma_idle;
         endcase
      end
   end

   always_ff @(posedge clock) begin
      if (start) begin
         src_page <= bus_wdata;
      end
   end

   assign dma_busy = (state != gb_io_pkg::dma_idle);
   assign dma_re   = (state == gb_io_pkg::dma_read);
   assign dma_we   = (state == gb_io_pkg::dma_write);

   // source byte arrives on bus_rdata in the write cycle
   assign dma_addr  = dma_we ? gb_map_pkg::oam_start + {8'h00, offset} : {src_page, offset};
   assign dma_wdata = bus_rdata;

endmodule

/* memory/gb_ram.sv */
/*
 * single-port byte RAM
 * synchronous read, write-first
 */
`timescale 1ns/10ps

module gb_ram #(
   parameter int depth = 256
) (
   input  logic                     clock,
   input  logic                     we,
   input  logic [$clog2(depth)-1:0] addr,
   input  gb_map_pkg::data_t        wdata,
   output gb_map_pkg::data_t        rdata
);

   gb_map_pkg::data_t mem [depth];

   // new byte shows on the read port in the write cycle
   always_ff @(posedge clock) begin
      if (we) begin
         mem[addr] <= wdata;
         rdata <= wdata;
      end else begin
         rdata <= mem[addr];
      end
   end

endmodule

/* sim.f */
+incdir+verification
common/gb_map_pkg.sv
common/gb_io_pkg.sv
memory/gb_ram.sv
timers/gb_timers.sv
timers/interrupt_regs.sv
dma/oam_dma.sv
verilog/bus_arbiter.sv
verilog/bus_decode.sv
verilog/gb_bus_top.sv
verification/tb_gb_bus.sv

/* timers/gb_timers.sv */
/*
 * timer block
 * free-running divider (DIV), TIMA with TMA reload, TAC control,
 * overflow interrupt pulse and registered read port
 */
`timescale 1ns/10ps

module gb_timers (
   input  logic               clock,
   input  logic               reset,
   input  logic               io_we,
   input  logic               bus_re,
   input  gb_map_pkg::addr_t  bus_addr,
   input  gb_map_pkg::data_t  bus_wdata,
   output gb_map_pkg::data_t  timer_rdata,
   output logic               timer_int
);

   logic [15:0]       div_cnt;
   logic [15:0]       div_step;
   logic [15:0]       tima_period;
   logic              tima_tick;
   gb_map_pkg::data_t tima;
   gb_map_pkg::data_t tma;
   logic [2:0]        tac;

   assign div_step = div_cnt / gb_io_pkg::div_period;

   always_comb begin
      case (tac[1:0])
         2'd0:    tima_period = gb_io_pkg::tima_period_0;
         2'd1:    tima_period = gb_io_pkg::tima_period_1;
         2'd2:    tima_period = gb_io_pkg::tima_period_2;
         default: tima_period = gb_io_pkg::tima_period_3;
      endcase
   end

   // periods are powers of two, so step on the divider's low bits
   assign tima_tick = tac[2] && ((div_cnt & (tima_period - 16'd1)) == (tima_period - 16'd1));

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         div_cnt   <= 16'd0;
         tima      <= 8'h00;
         tma       <= 8'h00;
         tac       <= 3'd0;
         timer_int <= 1'b0;
      end else begin
         timer_int <= 1'b0;

         // any write to DIV clears the whole divider
         if (io_we && bus_addr == gb_map_pkg::mmio_div) begin
            div_cnt <= 16'd0;
         end else begin
            div_cnt <= div_cnt + 16'd1;
         end

         if (io_we && bus_addr == gb_map_pkg::mmio_tma) begin
            tma <= bus_wdata;
         end
         if (io_we && bus_addr == gb_map_pkg::mmio_tac) begin
            tac <= bus_wdata[2:0];
         end

         // processor write beats a step in the same cycle
         if (io_we && bus_addr == gb_map_pkg::mmio_tima) begin
            tima <= bus_wdata;
         end else if (tima_tick) begin
            if (tima == 8'hFF) begin
               tima      <= tma;
               timer_int <= 1'b1;
            end else begin
               tima <= tima + 8'd1;
            end
         end
      end
   end

   always_ff @(posedge clock) begin
      if (bus_re) begin
         case (bus_addr)
            gb_map_pkg::mmio_div:  timer_rdata <= div_step[7:0];
            gb_map_pkg::mmio_tima: timer_rdata <= tima;
            gb_map_pkg::mmio_tma:  timer_rdata <= tma;
            gb_map_pkg::mmio_tac:  timer_rdata <= {5'b00000, tac};
            default:               timer_rdata <= 8'h00;
         endcase
      end
   end

endmodule

/* timers/interrupt_regs.sv */
/*
 * interrupt flag (IF) and enable (IE) registers
 * request capture and combined interrupt line
 */
`timescale 1ns/10ps

module interrupt_regs (
   input  logic               clock,
   input  logic               reset,
   input  logic               io_we,
   input  gb_map_pkg::addr_t  bus_addr,
   input  gb_map_pkg::data_t  bus_wdata,
   input  logic               timer_int,
   input  logic [1:0]         video_int_req,
   output gb_map_pkg::data_t  int_rdata,
   output logic               irq
);

   gb_io_pkg::int_t if_reg;
   gb_io_pkg::int_t ie_reg;
   gb_io_pkg::int_t if_base;
   gb_io_pkg::int_t int_set;

   always_comb begin
      int_set = '0;
      int_set[gb_io_pkg::int_vblank] = video_int_req[0];
      int_set[gb_io_pkg::int_lcdc]   = video_int_req[1];
      int_set[gb_io_pkg::int_timer]  = timer_int;
   end

   // write replaces IF, fresh requests still land on top
   assign if_base = (io_we && bus_addr == gb_map_pkg::mmio_if) ?
                    bus_wdata[4:0] & gb_io_pkg::int_live_mask : if_reg;

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         if_reg <= '0;
         ie_reg <= '0;
      end else begin
         if_reg <= if_base | int_set;
         if (io_we && bus_addr == gb_map_pkg::mmio_ie) begin
            ie_reg <= bus_wdata[4:0] & gb_io_pkg::int_live_mask;
         end
      end
   end

   // sampled every cycle, decoder picks it up only for IF/IE reads
   always_ff @(posedge clock) begin
      int_rdata <= {3'b000, (bus_addr == gb_map_pkg::mmio_ie) ? ie_reg : if_reg};
   end

   assign irq = |(if_reg & ie_reg);

endmodule

/* verification/tb_gb_tasks.svh */
/*
 * bus access tasks, compare tasks and the directed tests
 * work RAM, OAM and unmapped space, divider, timer interrupt, OAM DMA
 */

// strobe sampled at the next edge, write lands there too
task automatic bus_write(input gb_map_pkg::addr_t addr, input gb_map_pkg::data_t data);
   @(posedge clock);
   cpu_we    <= 1'b1;
   cpu_addr  <= addr;
   cpu_wdata <= data;
   @(posedge clock);
   cpu_we <= 1'b0;
endtask

// read data is stable from the edge after the strobe, sampled mid-cycle
task automatic bus_read(input gb_map_pkg::addr_t addr, output gb_map_pkg::data_t data);
   @(posedge clock);
   cpu_re   <= 1'b1;
   cpu_addr <= addr;
   @(posedge clock);
   cpu_re <= 1'b0;
   @(negedge clock);
   data = cpu_rdata;
endtask

task automatic check_data(input string name, input gb_map_pkg::data_t expected,
                          input gb_map_pkg::data_t actual);
   if (actual === expected) begin
      pass_count++;
   end else begin
      fail_count++;
      $display("mismatch %s: expected %h, got %h", name, expected, actual);
   end
endtask

task automatic check_range(input string name, input gb_map_pkg::data_t low,
                           input gb_map_pkg::data_t high, input gb_map_pkg::data_t actual);
   if (actual >= low && actual <= high) begin
      pass_count++;
   end else begin
      fail_count++;
      $display("mismatch %s: expected %h to %h, got %h", name, low, high, actual);
   end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
   if (actual === expected) begin
      pass_count++;
   end else begin
      fail_count++;
      $display("mismatch %s: expected %h, got %h", name, expected, actual);
   end
endtask

task automatic check_count(input string name, input int expected, input int actual);
   if (actual == expected) begin
      pass_count++;
   end else begin
      fail_count++;
      $display("mismatch %s: expected %h, got %h", name, expected, actual);
   end
endtask

task automatic report_test(input string name, input int fails_before);
   $display("%-20s %s, %0d errors", name,
            (fail_count == fails_before) ? "ok" : "failed", fail_count - fails_before);
endtask

task automatic wram_readback();
   gb_map_pkg::addr_t addr_list [32];
   gb_map_pkg::data_t model [gb_map_pkg::addr_t];
   gb_map_pkg::data_t value;
   int fails_before;
   fails_before = fail_count;
   for (int i = 0; i < 32; i++) begin
      addr_list[i] = gb_map_pkg::wram_start +
                     gb_map_pkg::addr_t'($urandom % gb_map_pkg::wram_depth);
      value = gb_map_pkg::data_t'($urandom);
      model[addr_list[i]] = value;
      bus_write(addr_list[i], value);
   end
   // repeated addresses expect their last byte
   for (int i = 0; i < 32; i++) begin
      bus_read(addr_list[i], value);
      check_data($sformatf("cpu_rdata @%h", addr_list[i]), model[addr_list[i]], value);
   end
   report_test("work RAM", fails_before);
endtask

task automatic oam_and_unmapped();
   gb_map_pkg::data_t value;
   int fails_before;
   fails_before = fail_count;
   bus_write(gb_map_pkg::wram_start, 8'h3C);
   bus_write(gb_map_pkg::oam_start, 8'hA5);
   bus_write(gb_map_pkg::oam_end, 8'h5A);
   bus_read(gb_map_pkg::wram_start, value);
   check_data("cpu_rdata @c000", 8'h3C, value);
   bus_read(gb_map_pkg::oam_start, value);
   check_data("cpu_rdata @fe00", 8'hA5, value);
   bus_read(gb_map_pkg::oam_end, value);
   check_data("cpu_rdata @fe9f", 8'h5A, value);
   bus_read(16'hFEA0, value);
   check_data("cpu_rdata @fea0", 8'h00, value);
   bus_read(16'h8000, value);
   check_data("cpu_rdata @8000", 8'h00, value);
   bus_read(16'hFF10, value);
   check_data("cpu_rdata @ff10", 8'h00, value);
   // writes into holes must leave mapped bytes alone
   // ff00 and 8000 land on offset 0 of the OAM and work RAM slices
   bus_write(16'hFEA0, 8'hFF);
   bus_write(16'hFF00, 8'hFF);
   bus_write(16'h8000, 8'hFF);
   bus_read(gb_map_pkg::wram_start, value);
   check_data("cpu_rdata @c000", 8'h3C, value);
   bus_read(gb_map_pkg::oam_start, value);
   check_data("cpu_rdata @fe00", 8'hA5, value);
   bus_read(gb_map_pkg::oam_end, value);
   check_data("cpu_rdata @fe9f", 8'h5A, value);
   bus_read(16'hFEA0, value);
   check_data("cpu_rdata @fea0", 8'h00, value);
   report_test("OAM and unmapped", fails_before);
endtask

task automatic divider_rate();
   gb_map_pkg::data_t value;
   int fails_before;
   fails_before = fail_count;
   bus_write(gb_map_pkg::mmio_div, 8'h5A);
   bus_read(gb_map_pkg::mmio_div, value);
   check_data("DIV", 8'h00, value);
   repeat (1000) @(posedge clock);
   // about 1004 clocks since the clear, one step per 256
   bus_read(gb_map_pkg::mmio_div, value);
   check_range("DIV", 8'h03, 8'h04, value);
   report_test("divider", fails_before);
endtask

task automatic timer_interrupt();
   gb_map_pkg::data_t value;
   int waited;
   int fails_before;
   fails_before = fail_count;
   bus_write(gb_map_pkg::mmio_ie, 8'(1 << gb_io_pkg::int_timer));
   bus_write(gb_map_pkg::mmio_tma, 8'hF0);
   bus_write(gb_map_pkg::mmio_tima, 8'hFE);
   bus_write(gb_map_pkg::mmio_tac, 8'h05);
   waited = 0;
   while (irq !== 1'b1 && waited < 100) begin
      @(negedge clock);
      waited++;
   end
   if (irq !== 1'b1) begin
      fail_count++;
      $display("irq did not rise within 100 cycles of starting the timer");
   end
   bus_read(gb_map_pkg::mmio_if, value);
   check_bit("IF timer bit", 1'b1, value[gb_io_pkg::int_timer]);
   bus_read(gb_map_pkg::mmio_tima, value);
   check_range("TIMA", 8'hF0, 8'hFF, value);
   // stop the timer so no second overflow lands
   bus_write(gb_map_pkg::mmio_tac, 8'h00);
   bus_write(gb_map_pkg::mmio_if, 8'h00);
   @(negedge clock);
   check_bit("irq", 1'b0, irq);
   bus_write(gb_map_pkg::mmio_ie,
             8'((1 << gb_io_pkg::int_vblank) | (1 << gb_io_pkg::int_timer)));
   @(negedge clock);
   check_bit("irq", 1'b0, irq);
   @(posedge clock);
   video_int_req <= 2'b01;
   @(posedge clock);
   video_int_req <= 2'b00;
   @(negedge clock);
   check_bit("irq", 1'b1, irq);
   bus_read(gb_map_pkg::mmio_if, value);
   check_data("IF", 8'(1 << gb_io_pkg::int_vblank), value);
   report_test("timer interrupt", fails_before);
endtask

task automatic dma_copy();
   gb_map_pkg::data_t source [160];
   gb_map_pkg::data_t value;
   int stall_cycles;
   int fails_before;
   fails_before = fail_count;
   for (int i = 0; i < 160; i++) begin
      source[i] = gb_map_pkg::data_t'($urandom);
      bus_write(16'hC100 + gb_map_pkg::addr_t'(i), source[i]);
   end
   bus_write(gb_map_pkg::mmio_dma, 8'hC1);
   @(negedge clock);
   check_bit("cpu_stall", 1'b1, cpu_stall);
   stall_cycles = 0;
   while (cpu_stall === 1'b1 && stall_cycles < 400) begin
      stall_cycles++;
      @(negedge clock);
   end
   // one read and one write cycle per byte
   check_count("cpu_stall cycles", 320, stall_cycles);
   for (int i = 0; i < 160; i++) begin
      bus_read(gb_map_pkg::oam_start + gb_map_pkg::addr_t'(i), value);
      check_data($sformatf("OAM byte %0d", i), source[i], value);
   end
   report_test("OAM DMA", fails_before);
endtask

/* verification/tb_gb_bus.sv */
/*
 * testbench top for the system bus
 * clock, reset, DUT, cycle limit and the directed test sequence
 */
`timescale 1ns/10ps

module tb_gb_bus;

   // the longest test sequence runs about 3000 cycles, so this leaves ample margin
   localparam int timeout_cycles = 20000;

   logic              clock = 1'b0;
   logic              reset;
   logic              cpu_re;
   logic              cpu_we;
   gb_map_pkg::addr_t cpu_addr;
   gb_map_pkg::data_t cpu_wdata;
   logic [1:0]        video_int_req;
   gb_map_pkg::data_t cpu_rdata;
   logic              cpu_stall;
   logic              irq;

   int pass_count = 0;
   int fail_count = 0;
   int cycle_count = 0;

   gb_bus_top i_gb_bus_top (
      .clock(clock),
      .reset(reset),
      .cpu_re(cpu_re),
      .cpu_we(cpu_we),
      .cpu_addr(cpu_addr),
      .cpu_wdata(cpu_wdata),
      .video_int_req(video_int_req),
      .cpu_rdata(cpu_rdata),
      .cpu_stall(cpu_stall),
      .irq(irq)
   );

   `include "tb_gb_tasks.svh"

   // 20 ns period
   always #10 clock = ~clock;

   always @(posedge clock) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_cycles) begin
         $display("run stopped after %0d cycles without finishing the tests", cycle_count);
         $display("TB FAILED");
         $finish;
      end
   end

   initial begin
      void'($urandom(32'h137f));
      cpu_re        <= 1'b0;
      cpu_we        <= 1'b0;
      cpu_addr      <= 16'h0000;
      cpu_wdata     <= 8'h00;
      video_int_req <= 2'b00;
      reset         <= 1'b1;
      repeat (3) @(posedge clock);
      reset <= 1'b0;

      wram_readback();
      oam_and_unmapped();
      divider_rate();
      timer_interrupt();
      dma_copy();

      $display("checks passed %0d, failed %0d", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

/* verilog/bus_arbiter.sv */
/*
 * bus arbiter between processor and OAM DMA
 * DMA owns the bus while busy, read data returned to its owner
 */
`timescale 1ns/10ps

module bus_arbiter (
   input  logic               clock,
   input  logic               reset,
   input  logic               cpu_re,
   input  logic               cpu_we,
   input  gb_map_pkg::addr_t  cpu_addr,
   input  gb_map_pkg::data_t  cpu_wdata,
   input  logic               dma_busy,
   input  logic               dma_re,
   input  logic               dma_we,
   input  gb_map_pkg::addr_t  dma_addr,
   input  gb_map_pkg::data_t  dma_wdata,
   input  gb_map_pkg::data_t  bus_rdata,
   output logic               bus_re,
   output logic               bus_we,
   output gb_map_pkg::addr_t  bus_addr,
   output gb_map_pkg::data_t  bus_wdata,
   output gb_map_pkg::data_t  cpu_rdata,
   output logic               cpu_stall
);

   logic              cpu_read_q;
   gb_map_pkg::data_t cpu_rdata_q;

   // processor strobes are dropped while DMA runs
   assign bus_re    = dma_busy ? dma_re    : cpu_re;
   assign bus_we    = dma_busy ? dma_we    : cpu_we;
   assign bus_addr  = dma_busy ? dma_addr  : cpu_addr;
   assign bus_wdata = dma_busy ? dma_wdata : cpu_wdata;
   assign cpu_stall = dma_busy;

   // owner of last cycle's read
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         cpu_read_q <= 1'b0;
      end else begin
         cpu_read_q <= cpu_re & ~dma_busy;
      end
   end

   // hold last processor byte across DMA reads
   always_ff @(posedge clock) begin
      if (cpu_read_q) begin
         cpu_rdata_q <= bus_rdata;
      end
   end

   assign cpu_rdata = cpu_read_q ? bus_rdata : cpu_rdata_q;

endmodule

/* verilog/bus_decode.sv */
/*
 * address decoder
 * region classification, write enables, RAM address slices,
 * read data mux aligned to the one-cycle RAM latency
 */
`timescale 1ns/10ps

module bus_decode (
   input  logic               clock,
   input  logic               reset,
   input  logic               bus_re,
   input  logic               bus_we,
   input  gb_map_pkg::addr_t  bus_addr,
   input  gb_map_pkg::data_t  wram_rdata,
   input  gb_map_pkg::data_t  oam_rdata,
   input  gb_map_pkg::data_t  timer_rdata,
   input  gb_map_pkg::data_t  int_rdata,
   output logic               wram_we,
   output logic               oam_we,
   output logic               io_we,
   output logic [12:0]        wram_addr,
   output logic [7:0]         oam_addr,
   output gb_map_pkg::data_t  bus_rdata
);

   gb_map_pkg::region_e region;
   gb_map_pkg::region_e rd_region;
   gb_map_pkg::addr_t   wram_offset;
   gb_map_pkg::addr_t   oam_offset;

   always_comb begin
      region = gb_map_pkg::region_io_none;
      if (bus_addr >= gb_map_pkg::wram_start && bus_addr <= gb_map_pkg::wram_end) begin
         region = gb_map_pkg::region_wram;
      end else if (bus_addr >= gb_map_pkg::oam_start && bus_addr <= gb_map_pkg::oam_end) begin
         region = gb_map_pkg::region_oam;
      end else if (bus_addr >= gb_map_pkg::mmio_div && bus_addr <= gb_map_pkg::mmio_tac) begin
         region = gb_map_pkg::region_timer;
      end else if (bus_addr == gb_map_pkg::mmio_if) begin
         region = gb_map_pkg::region_int_flag;
      end else if (bus_addr == gb_map_pkg::mmio_ie) begin
         region = gb_map_pkg::region_int_enable;
      end else if (bus_addr == gb_map_pkg::mmio_dma) begin
         region = gb_map_pkg::region_dma_reg;
      end
   end

   // offsets into the two RAMs
   assign wram_offset = bus_addr - gb_map_pkg::wram_start;
   assign oam_offset  = bus_addr - gb_map_pkg::oam_start;
   assign wram_addr   = wram_offset[12:0];
   assign oam_addr    = oam_offset[7:0];

   assign wram_we = bus_we && (region == gb_map_pkg::region_wram);
   assign oam_we  = bus_we && (region == gb_map_pkg::region_oam);
   assign io_we   = bus_we && (region == gb_map_pkg::region_timer ||
                               region == gb_map_pkg::region_int_flag ||
                               region == gb_map_pkg::region_int_enable ||
                               region == gb_map_pkg::region_dma_reg);

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         rd_region <= gb_map_pkg::region_none;
      end else begin
         rd_region <= bus_re ? region : gb_map_pkg::region_none;
      end
   end

   // DMA register and unmapped space read as 00
   always_comb begin
      case (rd_region)
         gb_map_pkg::region_wram:       bus_rdata = wram_rdata;
         gb_map_pkg::region_oam:        bus_rdata = oam_rdata;
         gb_map_pkg::region_timer:      bus_rdata = timer_rdata;
         gb_map_pkg::region_int_flag,
         gb_map_pkg::region_int_enable: bus_rdata = int_rdata;
         default:                       bus_rdata = 8'h00;
      endcase
   end

endmodule

/* verilog/gb_bus_top.sv */
/*
 * system bus top level
 * arbiter, decoder, work RAM, OAM, timers, interrupt registers, OAM DMA
 */
`timescale 1ns/10ps

module gb_bus_top (
   input  logic               clock,
   input  logic               reset,
   input  logic               cpu_re,
   input  logic               cpu_we,
   input  gb_map_pkg::addr_t  cpu_addr,
   input  gb_map_pkg::data_t  cpu_wdata,
   input  logic [1:0]         video_int_req,
   output gb_map_pkg::data_t  cpu_rdata,
   output logic               cpu_stall,
   output logic               irq
);

   // granted bus
   logic              bus_re;
   logic              bus_we;
   gb_map_pkg::addr_t bus_addr;
   gb_map_pkg::data_t bus_wdata;
   gb_map_pkg::data_t bus_rdata;

   // DMA master
   logic              dma_busy;
   logic              dma_re;
   logic              dma_we;
   gb_map_pkg::addr_t dma_addr;
   gb_map_pkg::data_t dma_wdata;

   // decoder side
   logic              wram_we;
   logic              oam_we;
   logic              io_we;
   logic [12:0]       wram_addr;
   logic [7:0]        oam_addr;
   gb_map_pkg::data_t wram_rdata;
   gb_map_pkg::data_t oam_rdata;
   gb_map_pkg::data_t timer_rdata;
   gb_map_pkg::data_t int_rdata;
   logic              timer_int;

   bus_arbiter i_arbiter (
      .clock(clock), .reset(reset),
      .cpu_re(cpu_re), .cpu_we(cpu_we), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
      .dma_busy(dma_busy), .dma_re(dma_re), .dma_we(dma_we),
      .dma_addr(dma_addr), .dma_wdata(dma_wdata),
      .bus_rdata(bus_rdata),
      .bus_re(bus_re), .bus_we(bus_we), .bus_addr(bus_addr), .bus_wdata(bus_wdata),
      .cpu_rdata(cpu_rdata), .cpu_stall(cpu_stall)
   );

   bus_decode i_decode (
      .clock(clock), .reset(reset),
      .bus_re(bus_re), .bus_we(bus_we), .bus_addr(bus_addr),
      .wram_rdata(wram_rdata), .oam_rdata(oam_rdata),
      .timer_rdata(timer_rdata), .int_rdata(int_rdata),
      .wram_we(wram_we), .oam_we(oam_we), .io_we(io_we),
      .wram_addr(wram_addr), .oam_addr(oam_addr), .bus_rdata(bus_rdata)
   );

   gb_ram #(.depth(gb_map_pkg::wram_depth)) i_wram (
      .clock(clock), .we(wram_we), .addr(wram_addr),
      .wdata(bus_wdata), .rdata(wram_rdata)
   );

   gb_ram #(.depth(gb_map_pkg::oam_depth)) i_oam (
      .clock(clock), .we(oam_we), .addr(oam_addr),
      .wdata(bus_wdata), .rdata(oam_rdata)
   );

   gb_timers i_timers (
      .clock(clock), .reset(reset),
      .io_we(io_we), .bus_re(bus_re), .bus_addr(bus_addr), .bus_wdata(bus_wdata),
      .timer_rdata(timer_rdata), .timer_int(timer_int)
   );

   interrupt_regs i_int_regs (
      .clock(clock), .reset(reset),
      .io_we(io_we), .bus_addr(bus_addr), .bus_wdata(bus_wdata),
      .timer_int(timer_int), .video_int_req(video_int_req),
      .int_rdata(int_rdata), .irq(irq)
   );

   oam_dma i_dma (
      .clock(clock), .reset(reset),
      .io_we(io_we), .bus_addr(bus_addr), .bus_wdata(bus_wdata), .bus_rdata(bus_rdata),
      .dma_busy(dma_busy), .dma_re(dma_re), .dma_we(dma_we),
      .dma_addr(dma_addr), .dma_wdata(dma_wdata)
   );

endmodule
